/* source/pipeControl_config.svh */
`ifndef PIPE_CONTROL_CONFIG_SVH
`define PIPE_CONTROL_CONFIG_SVH

// register file has 32 entries
`define REG_ADDR_WIDTH 5

// result latency in stages past EXE
// 0 alu, 1 mul or cp0 read, 2 load, 3 late result
`define LAT_WIDTH 2

// active level of the exception flush from the CP0 side
`define FLUSH_ENABLE 1'b1

`endif

/* source/pipeCtrlPkg.sv */
`include "pipeControl_config.svh"

package pipeCtrlPkg;

    // hazard-relevant view of one instruction
    typedef struct packed {
        logic                       valid;
        logic [`REG_ADDR_WIDTH-1:0] srcA;
        logic [`REG_ADDR_WIDTH-1:0] srcB;
        logic [`REG_ADDR_WIDTH-1:0] dest;
        logic                       writesReg;
        logic [`LAT_WIDTH-1:0]      resultLat;
    } instrTag_t;

    // status levels from caches, tlbs, mul/div unit and branch logic
    typedef struct packed {
        logic exceptionFlush;
        logic iTlbStall;
        logic dTlbStall;
        logic icacheBusy;
        logic dcacheBusy;
        logic predictFailed;
        logic pfFlushAll;
        logic isBranchLikely;
        logic isTaken;
        logic mulDivBusy;
    } pipeEvents_t;

    typedef struct packed {
        logic exStall;
        logic mem1Stall;
        logic mem2Stall;
    } dataHazard_t;

    typedef struct packed {
        // write enables
        logic preIfWr;
        logic ifWr;
        logic idWr;
        logic exeWr;
        logic memWr;
        logic mem2Wr;
        logic wbWr;
        // flushes
        logic ifFlush;
        logic idFlush;
        logic exeFlush;
        logic memFlush;
        logic mem2Flush;
        logic wbFlush;
        // side-effect write disables
        logic idDisWr;
        logic exeDisWr;
        logic memDisWr;
        logic wbDisWr;
        // cache interface
        logic iReqValid;
        logic dReqValid;
        logic icacheStall;
        logic dcacheStall;
    } stageCtrl_t;

    typedef struct packed {
        instrTag_t exe;
        instrTag_t mem;
        instrTag_t mem2;
        instrTag_t wb;
    } inFlight_t;

endpackage

/* source/hazardDecode.sv */
`timescale 1ns/1ps

`include "pipeControl_config.svh"

module hazardDecode (
    input  pipeCtrlPkg::instrTag_t   idInstr,
    input  pipeCtrlPkg::inFlight_t   inFlight,
    output pipeCtrlPkg::dataHazard_t hazard
);
    import pipeCtrlPkg::*;

    // producer in stage k blocks the consumer if its result is not
    // forwardable yet, i.e. resultLat >= k
    function automatic logic stageHit(
        input instrTag_t             consumer,
        input instrTag_t             producer,
        input logic [`LAT_WIDTH-1:0] minLat
    );
        logic srcMatch;
        srcMatch = (producer.dest == consumer.srcA) || (producer.dest == consumer.srcB);
        stageHit = consumer.valid
                && producer.valid
                && producer.writesReg
                && (producer.dest != '0)
                && srcMatch
                && (producer.resultLat >= minLat);
    endfunction

    localparam logic [`LAT_WIDTH-1:0] ExeLat  = `LAT_WIDTH'd1;
    localparam logic [`LAT_WIDTH-1:0] MemLat  = `LAT_WIDTH'd2;
    localparam logic [`LAT_WIDTH-1:0] Mem2Lat = `LAT_WIDTH'd3;

    always_comb begin
        hazard.exStall   = stageHit(idInstr, inFlight.exe, ExeLat);
        hazard.mem1Stall = stageHit(idInstr, inFlight.mem, MemLat);
        hazard.mem2Stall = stageHit(idInstr, inFlight.mem2, Mem2Lat);
    end

    // a bubble in ID must never hold the front end
    always_comb begin
        assert final (idInstr.valid !== 1'b0 || hazard == 3'b000)
            else $error("hazardDecode: stall raised for an invalid ID slot");
    end

endmodule

/* source/stallArbiter.sv */
`timescale 1ns/1ps

`include "pipeControl_config.svh"

module stallArbiter (
    input  pipeCtrlPkg::pipeEvents_t events,
    input  pipeCtrlPkg::dataHazard_t hazard,
    output pipeCtrlPkg::stageCtrl_t  ctrl
);
    import pipeCtrlPkg::*;

    logic excFlush;
    logic freeze;
    logic brLikelyFlush;
    logic cacheHold;

    assign excFlush = (events.exceptionFlush == `FLUSH_ENABLE);

    // dtlb/dcache, itlb/icache and mul/div all freeze the whole pipe the same way
    assign freeze = events.dTlbStall | events.dcacheBusy
                  | events.iTlbStall | events.icacheBusy
                  | events.mulDivBusy;

    // branch-likely with isTaken set squashes the slot in EXE
    assign brLikelyFlush = events.isBranchLikely & events.isTaken;

    always_comb begin
        ctrl = '0;
        if (freeze) begin
            ctrl.exeDisWr    = 1'b1;
            ctrl.memDisWr    = 1'b1;
            ctrl.wbDisWr     = 1'b1;
            ctrl.icacheStall = 1'b1;
            ctrl.dcacheStall = 1'b1;
        end else if (excFlush) begin
            ctrl.preIfWr  = 1'b1;
            ctrl.mem2Wr   = 1'b1;
            ctrl.wbWr     = 1'b1;
            ctrl.ifFlush  = 1'b1;
            ctrl.idFlush  = 1'b1;
            ctrl.exeFlush = 1'b1;
            ctrl.memFlush = 1'b1;
            ctrl.exeDisWr = 1'b1;
            ctrl.memDisWr = 1'b1;
        end else if (events.pfFlushAll) begin
            ctrl.preIfWr  = 1'b1;
            ctrl.exeWr    = 1'b1;
            ctrl.memWr    = 1'b1;
            ctrl.mem2Wr   = 1'b1;
            ctrl.wbWr     = 1'b1;
            ctrl.ifFlush  = 1'b1;
            ctrl.idFlush  = 1'b1;
            ctrl.exeFlush = 1'b1;
        end else if (hazard.mem2Stall) begin
            // bubble into mem2, everything up to mem holds
            ctrl.mem2Wr      = 1'b1;
            ctrl.wbWr        = 1'b1;
            ctrl.mem2Flush   = 1'b1;
            ctrl.memDisWr    = 1'b1;
            ctrl.icacheStall = 1'b1;
        end else if (hazard.mem1Stall) begin
            ctrl.memWr       = 1'b1;
            ctrl.mem2Wr      = 1'b1;
            ctrl.wbWr        = 1'b1;
            ctrl.memFlush    = 1'b1;
            ctrl.exeDisWr    = 1'b1;
            ctrl.icacheStall = 1'b1;
        end else if (hazard.exStall) begin
            ctrl.exeWr       = 1'b1;
            ctrl.memWr       = 1'b1;
            ctrl.mem2Wr      = 1'b1;
            ctrl.wbWr        = 1'b1;
            ctrl.exeFlush    = 1'b1;
            ctrl.idDisWr     = 1'b1;
            ctrl.icacheStall = 1'b1;
        end else if (events.predictFailed) begin
            ctrl.preIfWr  = 1'b1;
            ctrl.exeWr    = 1'b1;
            ctrl.memWr    = 1'b1;
            ctrl.mem2Wr   = 1'b1;
            ctrl.wbWr     = 1'b1;
            ctrl.ifFlush  = 1'b1;
            ctrl.idFlush  = 1'b1;
            ctrl.exeFlush = brLikelyFlush;
        end else begin
            ctrl.preIfWr  = 1'b1;
            ctrl.ifWr     = 1'b1;
            ctrl.idWr     = 1'b1;
            ctrl.exeWr    = 1'b1;
            ctrl.memWr    = 1'b1;
            ctrl.mem2Wr   = 1'b1;
            ctrl.wbWr     = 1'b1;
            ctrl.exeFlush = brLikelyFlush;
        end

        // request valids do not follow the table row
        ctrl.iReqValid = !(excFlush || (hazard != 3'b000)
                           || events.predictFailed || events.pfFlushAll);
        ctrl.dReqValid = !excFlush;
    end

    assign cacheHold = events.icacheBusy | events.dcacheBusy;

    always_comb begin
        assert final (excFlush !== 1'b1 || ctrl.iReqValid == 1'b0)
            else $error("stallArbiter: icache request issued during exception flush");
        // flushing a stage whose successor is frozen would drop an instruction
        assert final (cacheHold !== 1'b1
                      || ({ctrl.ifFlush, ctrl.idFlush, ctrl.exeFlush,
                           ctrl.memFlush, ctrl.mem2Flush}
                          & ~{ctrl.idWr, ctrl.exeWr, ctrl.memWr,
                              ctrl.mem2Wr, ctrl.wbWr}) == 5'b00000)
            else $error("stallArbiter: flush into a held stage on cache busy");
    end

endmodule

/* source/stageTracker.sv */
`timescale 1ns/1ps

module stageTracker (
    input  logic                   clk,
    input  logic                   arstN,
    input  pipeCtrlPkg::instrTag_t idInstr,
    input  pipeCtrlPkg::stageCtrl_t ctrl,
    output pipeCtrlPkg::inFlight_t inFlight
);
    import pipeCtrlPkg::*;

    localparam int NumStages = 4;

    // index 0 is EXE, 3 is WB
    logic [NumStages-1:0] stageWr;
    logic [NumStages-1:0] stageFlush;
    logic [NumStages-1:0] validQ;
    instrTag_t            payloadQ [NumStages];
    instrTag_t            curTag   [NumStages];
    instrTag_t            prevTag  [NumStages];

    assign stageWr    = {ctrl.wbWr, ctrl.mem2Wr, ctrl.memWr, ctrl.exeWr};
    assign stageFlush = {ctrl.wbFlush, ctrl.mem2Flush, ctrl.memFlush, ctrl.exeFlush};

    always_comb begin
        for (int s = 0; s < NumStages; s++) begin
            curTag[s]       = payloadQ[s];
            curTag[s].valid = validQ[s];
        end
        prevTag[0] = idInstr;
        for (int s = 1; s < NumStages; s++) begin
            prevTag[s] = curTag[s-1];
        end
    end

    // flush beats write
    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validQ <= '0;
        end else begin
            for (int s = 0; s < NumStages; s++) begin
                if (stageFlush[s]) begin
                    validQ[s] <= 1'b0;
                end else if (stageWr[s]) begin
                    validQ[s] <= prevTag[s].valid;
                end
            end
        end
    end

    // payload is don't-care while the valid bit is low
    always_ff @(posedge clk) begin
        for (int s = 0; s < NumStages; s++) begin
            if (stageWr[s]) begin
                payloadQ[s] <= prevTag[s];
            end
        end
    end

    assign inFlight.exe  = curTag[0];
    assign inFlight.mem  = curTag[1];
    assign inFlight.mem2 = curTag[2];
    assign inFlight.wb   = curTag[3];

    // register 0 is never a real write target
    assert property (@(posedge clk) disable iff (!arstN)
        (inFlight.wb.valid && inFlight.wb.writesReg) |-> (inFlight.wb.dest != '0))
        else $error("stageTracker: retiring write to register 0");

endmodule

/* source/pipeControlTop.sv */
`timescale 1ns/1ps

module pipeControlTop (
    input  logic                     clk,
    input  logic                     arstN,
    input  pipeCtrlPkg::pipeEvents_t events,
    input  pipeCtrlPkg::instrTag_t   idInstr,
    output pipeCtrlPkg::stageCtrl_t  ctrl,
    output pipeCtrlPkg::instrTag_t   retire
);
    import pipeCtrlPkg::*;

    inFlight_t   inFlight;
    dataHazard_t hazard;

    // ID against EXE/MEM/MEM2 producers
    hazardDecode i_hazardDecode (
        .idInstr  (idInstr),
        .inFlight (inFlight),
        .hazard   (hazard)
    );

    stallArbiter i_stallArbiter (
        .events (events),
        .hazard (hazard),
        .ctrl   (ctrl)
    );

    // tags follow the same enables and flushes as the datapath
    stageTracker i_stageTracker (
        .clk      (clk),
        .arstN    (arstN),
        .idInstr  (idInstr),
        .ctrl     (ctrl),
        .inFlight (inFlight)
    );

    assign retire = inFlight.wb;

endmodule

/* tests/tbPipeControl.sv */
`timescale 1ns/1ps

module tbPipeControl;
    import pipeCtrlPkg::*;

    // six tasks of at most 40 cycles plus reset, with margin
    localparam int MaxCycles = 400;

    logic        clk;
    logic        arstN;
    pipeEvents_t events;
    instrTag_t   idInstr;
    stageCtrl_t  ctrl;
    instrTag_t   retire;

    // reference tags, index 0 is EXE and 3 is WB
    instrTag_t   model [4];
    dataHazard_t expHz;
    stageCtrl_t  expCtrl;
    logic [3:0]  modelWr;
    logic [3:0]  modelFlush;
    logic        sawEx;
    logic        sawMem1;
    logic        sawMem2;
    instrTag_t   none;
    int          cycleCount;
    int          seed;

    pipeControlTop i_dut (
        .clk     (clk),
        .arstN   (arstN),
        .events  (events),
        .idInstr (idInstr),
        .ctrl    (ctrl),
        .retire  (retire)
    );

    always #50 clk = ~clk;

    task automatic abortRun();
        $display("TEST FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic reportMismatch(string name, logic [31:0] expVal, logic [31:0] actVal);
        $display("FAILED at %0t ns: %s expected %h actual %h", $time, name, expVal, actVal);
        abortRun();
    endtask

    function automatic instrTag_t makeTag(logic [4:0] srcA, logic [4:0] srcB,
                                          logic [4:0] dest, logic [1:0] lat);
        instrTag_t t;
        t.valid     = 1'b1;
        t.srcA      = srcA;
        t.srcB      = srcB;
        t.dest      = dest;
        t.writesReg = 1'b1;
        t.resultLat = lat;
        return t;
    endfunction

    // producer in stage k is not forwardable while its latency reaches k
    function automatic logic producerBlocks(instrTag_t id, instrTag_t p, logic [1:0] k);
        return id.valid && p.valid && p.writesReg && (p.dest != 5'd0)
            && (p.dest == id.srcA || p.dest == id.srcB) && (p.resultLat >= k);
    endfunction

    function automatic stageCtrl_t expectedCtrl(pipeEvents_t ev, dataHazard_t hz);
        stageCtrl_t c;
        logic       brFlush;
        c = '0;
        brFlush = ev.isBranchLikely && ev.isTaken;
        if (ev.dTlbStall || ev.dcacheBusy || ev.iTlbStall || ev.icacheBusy || ev.mulDivBusy) begin
            {c.exeDisWr, c.memDisWr, c.wbDisWr, c.icacheStall, c.dcacheStall} = 5'b11111;
        end else if (ev.exceptionFlush) begin
            {c.preIfWr, c.mem2Wr, c.wbWr} = 3'b111;
            {c.ifFlush, c.idFlush, c.exeFlush, c.memFlush, c.exeDisWr, c.memDisWr} = 6'h3f;
        end else if (ev.pfFlushAll) begin
            {c.preIfWr, c.exeWr, c.memWr, c.mem2Wr, c.wbWr} = 5'b11111;
            {c.ifFlush, c.idFlush, c.exeFlush} = 3'b111;
        end else if (hz.mem2Stall) begin
            {c.mem2Wr, c.wbWr, c.mem2Flush, c.memDisWr, c.icacheStall} = 5'b11111;
        end else if (hz.mem1Stall) begin
            {c.memWr, c.mem2Wr, c.wbWr, c.memFlush, c.exeDisWr, c.icacheStall} = 6'h3f;
        end else if (hz.exStall) begin
            {c.exeWr, c.memWr, c.mem2Wr, c.wbWr} = 4'hf;
            {c.exeFlush, c.idDisWr, c.icacheStall} = 3'b111;
        end else if (ev.predictFailed) begin
            {c.preIfWr, c.exeWr, c.memWr, c.mem2Wr, c.wbWr, c.ifFlush, c.idFlush} = 7'h7f;
            c.exeFlush = brFlush;
        end else begin
            {c.preIfWr, c.ifWr, c.idWr, c.exeWr, c.memWr, c.mem2Wr, c.wbWr} = 7'h7f;
            c.exeFlush = brFlush;
        end
        c.iReqValid = !(ev.exceptionFlush || hz != 3'b000 || ev.predictFailed || ev.pfFlushAll);
        c.dReqValid = !ev.exceptionFlush;
        return c;
    endfunction

    // compare, then step the reference one edge ahead
    always @(negedge clk) begin
        if (arstN) begin
            expHz.exStall   = producerBlocks(idInstr, model[0], 2'd1);
            expHz.mem1Stall = producerBlocks(idInstr, model[1], 2'd2);
            expHz.mem2Stall = producerBlocks(idInstr, model[2], 2'd3);
            sawEx   |= expHz.exStall;
            sawMem1 |= expHz.mem1Stall;
            sawMem2 |= expHz.mem2Stall;
            expCtrl = expectedCtrl(events, expHz);
            assert (ctrl === expCtrl) else reportMismatch("ctrl", expCtrl, ctrl);
            assert (retire.valid === model[3].valid)
                else reportMismatch("retire.valid", model[3].valid, retire.valid);
            if (model[3].valid) begin
                assert (retire === model[3]) else reportMismatch("retire", model[3], retire);
            end
            modelWr    = {ctrl.wbWr, ctrl.mem2Wr, ctrl.memWr, ctrl.exeWr};
            modelFlush = {ctrl.wbFlush, ctrl.mem2Flush, ctrl.memFlush, ctrl.exeFlush};
            for (int s = 3; s >= 0; s--) begin
                if (modelFlush[s]) begin
                    model[s].valid = 1'b0;
                end else if (modelWr[s]) begin
                    model[s] = (s == 0) ? idInstr : model[s-1];
                end
            end
        end
    end

    always @(posedge clk) begin
        cycleCount++;
        if (cycleCount >= MaxCycles) begin
            $display("timeout: the run did not finish within %0d cycles", MaxCycles);
            abortRun();
        end
    end

    // one cycle of stimulus, returns where outputs are stable
    task automatic drive(instrTag_t tag, pipeEvents_t ev);
        @(posedge clk);
        #10;
        idInstr = tag;
        events  = ev;
        @(negedge clk);
    endtask

    // keep presenting the tag until ID moves on
    task automatic issue(instrTag_t tag);
        drive(tag, '0);
        while (!ctrl.idWr && !ctrl.idFlush) begin
            drive(tag, '0);
        end
    endtask

    task automatic runCycles(pipeEvents_t ev, int n);
        repeat (n) drive(none, ev);
    endtask

    task automatic waitRetire(logic [4:0] dest);
        do begin
            drive(none, '0);
        end while (!(retire.valid && retire.dest == dest));
    endtask

    task automatic flowAfterReset();
        instrTag_t  tags [8];
        stageCtrl_t idle;
        idle = '0;
        {idle.preIfWr, idle.ifWr, idle.idWr, idle.exeWr, idle.memWr, idle.mem2Wr} = 6'h3f;
        {idle.wbWr, idle.iReqValid, idle.dReqValid} = 3'b111;
        @(negedge clk);
        assert (ctrl === idle) else reportMismatch("ctrl", idle, ctrl);
        foreach (tags[i]) begin
            tags[i] = makeTag(5'($random(seed)), 5'($random(seed)),
                              5'({$random(seed)} % 31 + 1), 2'd0);
        end
        for (int j = 0; j < 12; j++) begin
            drive((j < 8) ? tags[j] : none, '0);
            if (j >= 4) begin
                assert (retire === tags[j-4]) else reportMismatch("retire", tags[j-4], retire);
            end
        end
    endtask

    task automatic dataHazards();
        {sawEx, sawMem1, sawMem2} = 3'b000;
        issue(makeTag(5'd1, 5'd2, 5'd5, 2'd2));
        issue(makeTag(5'd5, 5'd3, 5'd6, 2'd0));
        waitRetire(5'd6);
        assert (sawEx && sawMem1) else begin
            $display("load-use pair did not raise exStall and mem1Stall");
            abortRun();
        end
        issue(makeTag(5'd2, 5'd3, 5'd7, 2'd3));
        issue(makeTag(5'd4, 5'd7, 5'd8, 2'd0));
        waitRetire(5'd8);
        assert (sawMem2) else begin
            $display("late-result producer did not raise mem2Stall");
            abortRun();
        end
    endtask

    task automatic freezeStep(pipeEvents_t ev);
        instrTag_t held;
        drive(none, ev);
        held = retire;
        repeat (2) begin
            drive(none, ev);
            assert (retire === held) else reportMismatch("retire", held, retire);
            assert (!ctrl.wbWr && ctrl.dcacheStall) else reportMismatch("ctrl", 0, ctrl);
        end
    endtask

    task automatic freezeHolds();
        pipeEvents_t ev;
        issue(makeTag(5'd1, 5'd2, 5'd10, 2'd0));
        issue(makeTag(5'd3, 5'd4, 5'd11, 2'd1));
        ev = '0;
        ev.dTlbStall = 1'b1;
        freezeStep(ev);
        ev = '0;
        ev.dcacheBusy = 1'b1;
        freezeStep(ev);
        ev = '0;
        ev.iTlbStall = 1'b1;
        freezeStep(ev);
        ev = '0;
        ev.icacheBusy = 1'b1;
        freezeStep(ev);
        ev = '0;
        ev.mulDivBusy = 1'b1;
        freezeStep(ev);
        waitRetire(5'd11);
    endtask

    task automatic excFlushRecovery();
        pipeEvents_t ev;
        ev = '0;
        ev.exceptionFlush = 1'b1;
        for (int d = 12; d < 16; d++) begin
            issue(makeTag(5'd1, 5'd2, 5'(d), 2'd0));
        end
        drive(makeTag(5'd1, 5'd2, 5'd16, 2'd0), ev);
        assert (!ctrl.iReqValid && !ctrl.dReqValid) else reportMismatch("ctrl", 0, ctrl);
        repeat (6) begin
            drive(none, '0);
            // the EXE occupant and the ID slot must never retire
            assert (!(retire.valid && retire.dest inside {5'd15, 5'd16}))
                else reportMismatch("retire.dest", 0, retire.dest);
        end
    endtask

    task automatic branchRecovery();
        pipeEvents_t ev;
        issue(makeTag(5'd1, 5'd2, 5'd17, 2'd0));
        ev = '0;
        ev.predictFailed = 1'b1;
        drive(makeTag(5'd3, 5'd4, 5'd18, 2'd0), ev);
        assert (ctrl.ifFlush && ctrl.idFlush && !ctrl.exeFlush)
            else reportMismatch("ctrl", 0, ctrl);
        {ev.isBranchLikely, ev.isTaken} = 2'b11;
        drive(makeTag(5'd3, 5'd4, 5'd19, 2'd0), ev);
        assert (ctrl.exeFlush === 1'b1) else reportMismatch("ctrl.exeFlush", 1, ctrl.exeFlush);
        ev = '0;
        ev.pfFlushAll = 1'b1;
        drive(makeTag(5'd3, 5'd4, 5'd20, 2'd0), ev);
        assert (ctrl.exeFlush && ctrl.ifFlush) else reportMismatch("ctrl", 0, ctrl);
        ev = '0;
        {ev.isBranchLikely, ev.isTaken} = 2'b11;
        drive(makeTag(5'd3, 5'd4, 5'd21, 2'd0), ev);
        assert (ctrl.exeFlush && !ctrl.ifFlush && ctrl.idWr)
            else reportMismatch("ctrl", 0, ctrl);
        runCycles('0, 5);
    endtask

    task automatic causePriority();
        pipeEvents_t ev;
        instrTag_t   dep;
        sawEx = 1'b0;
        dep = makeTag(5'd22, 5'd1, 5'd23, 2'd0);
        issue(makeTag(5'd1, 5'd2, 5'd22, 2'd2));
        ev = '0;
        {ev.dcacheBusy, ev.exceptionFlush} = 2'b11;
        drive(dep, ev);
        assert (ctrl.dcacheStall && !ctrl.ifFlush && !ctrl.preIfWr)
            else reportMismatch("ctrl", 0, ctrl);
        ev = '0;
        ev.mulDivBusy = 1'b1;
        drive(dep, ev);
        assert (!ctrl.exeWr && !ctrl.exeFlush && ctrl.dcacheStall)
            else reportMismatch("ctrl", 0, ctrl);
        ev = '0;
        ev.pfFlushAll = 1'b1;
        drive(dep, ev);
        assert (ctrl.ifFlush && ctrl.exeFlush && ctrl.preIfWr && !ctrl.idDisWr)
            else reportMismatch("ctrl", 0, ctrl);
        assert (sawEx) else begin
            $display("load-use pair raised no hazard under the competing causes");
            abortRun();
        end
        runCycles('0, 5);
    endtask

    initial begin
        seed       = 12433;
        clk        = 1'b0;
        arstN      = 1'b0;
        events     = '0;
        idInstr    = '0;
        none       = '0;
        cycleCount = 0;
        {sawEx, sawMem1, sawMem2} = 3'b000;
        foreach (model[s]) begin
            model[s] = '0;
        end
        repeat (3) @(posedge clk);
        #10;
        arstN = 1'b1;
        flowAfterReset();
        dataHazards();
        freezeHolds();
        excFlushRecovery();
        branchRecovery();
        causePriority();
        $display("TEST OK");
        $finish;
    end

endmodule

/* vlog.f */
+incdir+source
source/pipeCtrlPkg.sv
source/hazardDecode.sv
source/stallArbiter.sv
source/stageTracker.sv
source/pipeControlTop.sv
tests/tbPipeControl.sv

/* Bender.yml */
package:
  name: pipe_control

sources:
  - include_dirs:
      - source
    files:
      - source/pipeCtrlPkg.sv
      - source/hazardDecode.sv
      - source/stallArbiter.sv
      - source/stageTracker.sv
      - source/pipeControlTop.sv
  - target: test
    files:
      - tests/tbPipeControl.sv
